/* tb.f */
common/harness_pkg.sv
hdl/harness_ctrl.sv
msg_source/msg_source.sv
msg_sink/msg_sink.sv
hdl/msg_queue.sv
hdl/channel_harness.sv
tests/channel_harness_asserts.sv
tests/channel_harness_tb.sv

/* Makefile */
# Verilator build for the channel replay harness

VERILATOR ?= verilator
TOP       ?= channel_harness_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
sim: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/channel_harness_tb.sv */
// Channel harness testbench
// Table-driven runs through the replay harness with result checks

`timescale 1ns/1ps
`default_nettype none

module channel_harness_tb;

  import harness_pkg::*;

  localparam int max_msgs = 64;
  localparam int n_runs   = 8;

  //--------------------------------------------------------------------
  // Run table
  //--------------------------------------------------------------------

  // Sink entries bad_first .. bad_first+bad_cnt-1 are inverted
  typedef struct packed {
    int n;
    int mask;
    int bad_first;
    int bad_cnt;
    int extra_start;
    int mid_load;
    int exp_errors;
    int exp_first;
  } run_t;

  // n, mask, bad_first, bad_cnt, extra_start, mid_load, errors, first
  run_t runs [n_runs] = '{
    '{ 8, 'h00, 0, 0, 0, 0, 0, 63},
    '{16, 'hb7, 0, 0, 0, 0, 0, 63},
    '{12, 'h55, 0, 3, 0, 0, 3,  0},
    '{10, 'h00, 5, 1, 0, 0, 1,  5},
    '{ 1, 'h00, 0, 0, 0, 0, 0, 63},
    '{64, 'h33, 0, 0, 0, 0, 0, 63},
    '{20, 'h81, 0, 0, 1, 0, 0, 63},
    '{16, 'h0c, 0, 0, 0, 1, 0, 63}
  };

  logic       clk = 1'b0;
  logic       reset;
  logic       load_en;
  logic       load_sel;
  logic [5:0] load_addr;
  msg_t       load_data;
  logic [6:0] num_msgs;
  logic [7:0] stall_mask;
  logic       start;
  logic       busy;
  logic       done;
  logic [6:0] error_count;
  logic [5:0] first_error;

  msg_t words [max_msgs];
  int   errors = 0;
  int   tests_failed = 0;

  channel_harness #(.max_msgs(max_msgs), .queue_depth(4)) i_dut (
    .clk(clk), .reset(reset), .load_en(load_en), .load_sel(load_sel),
    .load_addr(load_addr), .load_data(load_data), .num_msgs(num_msgs),
    .stall_mask(stall_mask), .start(start), .busy(busy), .done(done),
    .error_count(error_count), .first_error(first_error)
  );

  always #2 clk = ~clk;

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------

  // Sample and drive point 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Four-state compare so an unknown output never matches
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got == exp) else begin
      $display("error: time %0t %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // Random source words with the bad range inverted in the sink copy
  task automatic load_tables(input run_t r);
    for (int k = 0; k < r.n; k++) begin
      words[k] = $urandom;
      next_cycle();
      load_en   = 1'b1;
      load_sel  = 1'b0;
      load_addr = 6'(k);
      load_data = words[k];
    end
    for (int k = 0; k < r.n; k++) begin
      next_cycle();
      load_sel  = 1'b1;
      load_addr = 6'(k);
      load_data = (k >= r.bad_first && k < r.bad_first + r.bad_cnt) ? ~words[k] : words[k];
    end
  endtask

  task automatic apply_run(input int t);
    run_t r;
    int   cyc;
    int   errs_before;
    r = runs[t];
    errs_before = errors;
    load_tables(r);
    next_cycle();
    load_en    = 1'b0;
    num_msgs   = 7'(r.n);
    stall_mask = 8'(r.mask);
    start      = 1'b1;
    next_cycle();
    start = 1'b0;
    compare_value("done", 32'(done), 0);
    cyc = 0;
    while (!done) begin
      compare_value("busy", 32'(busy), 1);
      next_cycle();
      cyc++;
      // Second start with another count lands mid-run
      if (r.extra_start != 0 && cyc == 3) begin
        start    = 1'b1;
        num_msgs = 7'd5;
      end else if (r.extra_start != 0 && cyc == 4) begin
        start    = 1'b0;
        num_msgs = 7'(r.n);
      end
      // Stray table writes while busy
      if (r.mid_load != 0) begin
        load_en   = (cyc >= 2 && cyc < 6);
        load_sel  = cyc[0];
        load_addr = 6'(cyc);
        load_data = 32'hdead_0000 | 32'(cyc);
      end
    end
    load_en = 1'b0;
    assert (cyc >= r.n + 2) else begin
      $display("done came %0d cycles after start, too soon for %0d messages", cyc, r.n);
      errors++;
    end
    compare_value("busy", 32'(busy), 0);
    compare_value("error_count", 32'(error_count), r.exp_errors);
    compare_value("first_error", 32'(first_error), r.exp_first);
    // Done holds until the next start
    next_cycle();
    compare_value("done", 32'(done), 1);
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test %0d: %0d msgs, mask %b, %0d cycles, %s", t, r.n, 8'(r.mask), cyc,
             (errors == errs_before) ? "ok" : "FAIL");
  endtask

  function automatic int watchdog_cycles();
    int total;
    total = 200;
    foreach (runs[i]) begin
      total += 8 * (runs[i].n + 10);
    end
    return total;
  endfunction

  //--------------------------------------------------------------------
  // Watchdog
  //--------------------------------------------------------------------

  initial begin
    repeat (watchdog_cycles()) @(posedge clk);
    $display("watchdog expired after %0d cycles, a run never finished", watchdog_cycles());
    $display("Testbench failed");
    $finish;
  end

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------

  initial begin
    int errs_before;
    int bound_fails;
    void'($urandom(32'hd1fb9662));
    reset      = 1'b0;
    load_en    = 1'b0;
    load_sel   = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    num_msgs   = '0;
    stall_mask = '0;
    start      = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b1;

    // Outputs straight out of reset
    errs_before = errors;
    compare_value("busy", 32'(busy), 0);
    compare_value("done", 32'(done), 0);
    compare_value("error_count", 32'(error_count), 0);
    compare_value("first_error", 32'(first_error), 63);
    if (errors != errs_before) begin
      tests_failed++;
    end
    $display("test reset: %s", (errors == errs_before) ? "ok" : "FAIL");

    for (int t = 0; t < n_runs; t++) begin
      apply_run(t);
    end

    bound_fails = i_dut.i_source.i_src_asserts.fail_count
                + i_dut.i_queue.i_queue_asserts.fail_count
                + i_dut.i_ctrl.i_ctrl_asserts.fail_count;
    assert (bound_fails == 0) else begin
      $display("bound assertions fired %0d times", bound_fails);
      errors++;
    end

    $display("%0d tests, %0d failed, %0d errors", n_runs + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/channel_harness_asserts.sv */
// Channel harness assertions
// Link stability on val/rdy and control state sanity, bound into the DUT

`timescale 1ns/1ps
`default_nettype none

module channel_harness_asserts #(
  parameter bit has_link = 1'b1,
  parameter bit has_ctrl = 1'b0
) (
  input wire logic                        clk,
  input wire logic                        reset,
  input wire logic                        val,
  input wire logic                        rdy,
  input wire logic [31:0]                 msg,
  input wire logic                        busy,
  input wire logic                        done,
  input wire harness_pkg::harness_state_t state
);

  import harness_pkg::*;

  // Read back by the testbench at the end of the run
  int fail_count = 0;

  //--------------------------------------------------------------------
  // Sender side of a val/rdy link
  //--------------------------------------------------------------------

  if (has_link) begin : g_link
    // A held message must not move until it is taken
    assert property (@(posedge clk) disable iff (!reset)
      val && !rdy |=> val && $stable(msg))
    else begin
      $error("val dropped or msg changed while rdy was low");
      fail_count++;
    end
  end

  //--------------------------------------------------------------------
  // Control FSM
  //--------------------------------------------------------------------

  if (has_ctrl) begin : g_ctrl
    assert property (@(posedge clk) disable iff (!reset) !(done && busy))
    else begin
      $error("done and busy high in the same cycle");
      fail_count++;
    end

    // Synchronous reset lands the FSM in idle
    assert property (@(posedge clk) !reset |=> state == state_idle)
    else begin
      $error("control state not idle after reset");
      fail_count++;
    end
  end

endmodule

bind msg_source channel_harness_asserts #(.has_link(1'b1), .has_ctrl(1'b0)) i_src_asserts (
  .clk(clk), .reset(reset), .val(val), .rdy(rdy), .msg(msg),
  .busy(1'b0), .done(1'b0), .state(harness_pkg::state_idle)
);

bind msg_queue channel_harness_asserts #(.has_link(1'b1), .has_ctrl(1'b0)) i_queue_asserts (
  .clk(clk), .reset(reset), .val(deq_val), .rdy(deq_rdy), .msg(deq_msg),
  .busy(1'b0), .done(1'b0), .state(harness_pkg::state_idle)
);

bind harness_ctrl channel_harness_asserts #(.has_link(1'b0), .has_ctrl(1'b1)) i_ctrl_asserts (
  .clk(clk), .reset(reset), .val(1'b0), .rdy(1'b0), .msg(32'h0),
  .busy(busy), .done(done), .state(state)
);

`default_nettype wire

/* hdl/channel_harness.sv */
// Channel replay harness
// Control, message source, queue under test and checking sink

`timescale 1ns/1ps
`default_nettype none

module channel_harness #(
  parameter int max_msgs    = harness_pkg::MAX_MSGS,
  parameter int queue_depth = 4
) (
  input  wire logic                           clk,
  input  wire logic                           reset,
  // Table loading, sel 0 for source and 1 for sink
  input  wire logic                           load_en,
  input  wire logic                           load_sel,
  input  wire logic [$clog2(max_msgs)-1:0]    load_addr,
  input  wire harness_pkg::msg_t              load_data,
  // Run setup
  input  wire logic [$clog2(max_msgs+1)-1:0]  num_msgs,
  input  wire logic [7:0]                     stall_mask,
  input  wire logic                           start,
  // Results
  output logic                                busy,
  output logic                                done,
  output logic [$clog2(max_msgs+1)-1:0]       error_count,
  output logic [$clog2(max_msgs)-1:0]         first_error
);

  import harness_pkg::*;

  localparam int cnt_w = $clog2(max_msgs + 1);

  //--------------------------------------------------------------------
  // Control to datapath
  //--------------------------------------------------------------------

  logic             src_wr_en;
  logic             snk_wr_en;
  logic             arm;
  logic             run;
  logic [cnt_w-1:0] count;
  logic             all_rcvd;

  // Source to queue and queue to sink links
  logic src_val;
  logic src_rdy;
  msg_t src_msg;
  logic snk_val;
  logic snk_rdy;
  msg_t snk_msg;

  harness_ctrl #(.max_msgs(max_msgs)) i_ctrl (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_sel  (load_sel),
    .start     (start),
    .num_msgs  (num_msgs),
    .all_rcvd  (all_rcvd),
    .src_wr_en (src_wr_en),
    .snk_wr_en (snk_wr_en),
    .arm       (arm),
    .run       (run),
    .count     (count),
    .busy      (busy),
    .done      (done)
  );

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  msg_source #(.max_msgs(max_msgs)) i_source (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (src_wr_en),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .arm     (arm),
    .run     (run),
    .count   (count),
    .rdy     (src_rdy),
    .val     (src_val),
    .msg     (src_msg)
  );

  msg_queue #(.payload_t(msg_t), .queue_depth(queue_depth)) i_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (src_val),
    .enq_msg (src_msg),
    .enq_rdy (src_rdy),
    .deq_rdy (snk_rdy),
    .deq_val (snk_val),
    .deq_msg (snk_msg)
  );

  msg_sink #(.max_msgs(max_msgs)) i_sink (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (snk_wr_en),
    .wr_addr     (load_addr),
    .wr_data     (load_data),
    .arm         (arm),
    .run         (run),
    .count       (count),
    .stall_mask  (stall_mask),
    .val         (snk_val),
    .msg         (snk_msg),
    .rdy         (snk_rdy),
    .all_rcvd    (all_rcvd),
    .error_count (error_count),
    .first_error (first_error)
  );

endmodule

`default_nettype wire

/* hdl/msg_queue.sv */
// Message queue
// Circular buffer with val/rdy on both sides, carries any payload type

`timescale 1ns/1ps
`default_nettype none

module msg_queue #(
  parameter type payload_t   = logic [31:0],
  parameter int  queue_depth = 4
) (
  input  wire logic clk,
  input  wire logic reset,
  // Enqueue side
  input  wire logic enq_val,
  input  wire payload_t enq_msg,
  output logic      enq_rdy,
  // Dequeue side
  input  wire logic deq_rdy,
  output logic      deq_val,
  output payload_t  deq_msg
);

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int occ_w = $clog2(queue_depth + 1);

  //--------------------------------------------------------------------
  // Storage and pointers
  //--------------------------------------------------------------------

  payload_t         mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [occ_w-1:0] occ;
  logic             do_enq;
  logic             do_deq;

  // Full blocks enqueue even when a dequeue is under way
  assign enq_rdy = (occ != occ_w'(queue_depth));
  assign deq_val = (occ != '0);
  assign deq_msg = mem[rd_ptr];

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      // Pointers wrap at the last slot
      if (do_enq) begin
        wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous enq and deq leave the occupancy unchanged
      case ({do_enq, do_deq})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* msg_sink/msg_sink.sv */
// Message sink
// Checks incoming messages against an expected table under a stall pattern

`timescale 1ns/1ps
`default_nettype none

module msg_sink #(
  parameter int max_msgs = harness_pkg::MAX_MSGS
) (
  input  wire logic                           clk,
  input  wire logic                           reset,
  // Table load port
  input  wire logic                           wr_en,
  input  wire logic [$clog2(max_msgs)-1:0]    wr_addr,
  input  wire harness_pkg::msg_t              wr_data,
  // Run control
  input  wire logic                           arm,
  input  wire logic                           run,
  input  wire logic [$clog2(max_msgs+1)-1:0]  count,
  input  wire logic [7:0]                     stall_mask,
  // Incoming val/rdy link
  input  wire logic                           val,
  input  wire harness_pkg::msg_t              msg,
  output logic                                rdy,
  // Results
  output logic                                all_rcvd,
  output logic [$clog2(max_msgs+1)-1:0]       error_count,
  output logic [$clog2(max_msgs)-1:0]         first_error
);

  import harness_pkg::*;

  localparam int idx_w = $clog2(max_msgs);
  localparam int cnt_w = $clog2(max_msgs + 1);

  //--------------------------------------------------------------------
  // State
  //--------------------------------------------------------------------

  msg_t             exp_tbl [max_msgs];
  logic [cnt_w-1:0] rcv_idx;
  logic [2:0]       stall_cnt;
  logic             accept;
  logic             mismatch;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      exp_tbl[wr_addr] <= wr_data;
    end
  end

  //--------------------------------------------------------------------
  // Back-pressure
  //--------------------------------------------------------------------

  // Free-running phase counter picks one mask bit per cycle
  always_ff @(posedge clk) begin
    if (!reset || arm) begin
      stall_cnt <= '0;
    end else begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  // A set mask bit stalls that cycle
  assign rdy    = run && !stall_mask[stall_cnt];
  assign accept = val && rdy;

  //--------------------------------------------------------------------
  // Compare and count
  //--------------------------------------------------------------------

  assign mismatch = (msg != exp_tbl[rcv_idx[idx_w-1:0]]);

  always_ff @(posedge clk) begin
    if (!reset || arm) begin
      rcv_idx     <= '0;
      error_count <= '0;
      first_error <= '1;
    end else if (accept) begin
      rcv_idx <= rcv_idx + 1'b1;
      if (mismatch) begin
        // No errors so far means this is the first one
        if (error_count == '0) begin
          first_error <= rcv_idx[idx_w-1:0];
        end
        // Saturate instead of wrapping
        if (error_count != '1) begin
          error_count <= error_count + 1'b1;
        end
      end
    end
  end

  // Whole latched count has arrived
  assign all_rcvd = (rcv_idx == count);

endmodule

`default_nettype wire

/* msg_source/msg_source.sv */
// Message source
// Replays a table of messages in order over a val/rdy link

`timescale 1ns/1ps
`default_nettype none

module msg_source #(
  parameter int max_msgs = harness_pkg::MAX_MSGS
) (
  input  wire logic                           clk,
  input  wire logic                           reset,
  // Table load port
  input  wire logic                           wr_en,
  input  wire logic [$clog2(max_msgs)-1:0]    wr_addr,
  input  wire harness_pkg::msg_t              wr_data,
  // Run control
  input  wire logic                           arm,
  input  wire logic                           run,
  input  wire logic [$clog2(max_msgs+1)-1:0]  count,
  // Outgoing val/rdy link
  input  wire logic                           rdy,
  output logic                                val,
  output harness_pkg::msg_t                   msg
);

  import harness_pkg::*;

  //--------------------------------------------------------------------
  // Local parameters
  //--------------------------------------------------------------------

  // Table address width and sent-count width (one more state for "all sent")
  localparam int idx_w = $clog2(max_msgs);
  localparam int cnt_w = $clog2(max_msgs + 1);

  //--------------------------------------------------------------------
  // State
  //--------------------------------------------------------------------

  // Messages to send
  msg_t tbl [max_msgs];

  // Next message to send, doubles as the sent count
  logic [cnt_w-1:0] index;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tbl[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      index <= '0;
    end else if (arm) begin
      index <= '0;
    end else if (val && rdy) begin
      // Bump once per transfer
      index <= index + 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // Outgoing link
  //--------------------------------------------------------------------

  // Combinational table read at the current index
  assign msg = tbl[index[idx_w-1:0]];

  // Valid until the latched count has gone out
  assign val = run && (index < count);

endmodule

`default_nettype wire

/* hdl/harness_ctrl.sv */
// Harness control
// Routes table writes, starts a run with an arm pulse and flags completion

`timescale 1ns/1ps
`default_nettype none

module harness_ctrl #(
  parameter int max_msgs = harness_pkg::MAX_MSGS
) (
  input  wire logic                           clk,
  input  wire logic                           reset,
  input  wire logic                           load_en,
  input  wire logic                           load_sel,
  input  wire logic                           start,
  input  wire logic [$clog2(max_msgs+1)-1:0]  num_msgs,
  input  wire logic                           all_rcvd,
  output logic                                src_wr_en,
  output logic                                snk_wr_en,
  output logic                                arm,
  output logic                                run,
  output logic [$clog2(max_msgs+1)-1:0]       count,
  output logic                                busy,
  output logic                                done
);

  import harness_pkg::*;

  harness_state_t state;

  //--------------------------------------------------------------------
  // Table write routing
  //--------------------------------------------------------------------

  // Writes reach the tables only while no run is active
  assign src_wr_en = (state == state_idle) && load_en && !load_sel;
  assign snk_wr_en = (state == state_idle) && load_en && load_sel;

  //--------------------------------------------------------------------
  // Sequencer
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= state_idle;
      arm   <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      // Arm lasts exactly one cycle
      arm <= 1'b0;
      case (state)
        state_idle: begin
          if (start) begin
            // Latched count stays put for the whole run
            count <= num_msgs;
            arm   <= 1'b1;
            done  <= 1'b0;
            state <= state_run;
          end
        end
        state_run: begin
          // Sink counters are only valid once arm has cleared them
          if (!arm && all_rcvd) begin
            done  <= 1'b1;
            state <= state_finish;
          end
        end
        state_finish: begin
          state <= state_idle;
        end
        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

  // Datapath runs after the arm cycle
  assign run  = (state == state_run) && !arm;
  assign busy = (state == state_run);

endmodule

`default_nettype wire

/* common/harness_pkg.sv */
// Harness package
// Message format, table depth and control states shared by the replay harness

`default_nettype none

package harness_pkg;

  //--------------------------------------------------------------------
  // Message format
  //--------------------------------------------------------------------

  // 8-bit tag in the upper byte, 24-bit data word below it
  typedef struct packed {
    logic [7:0]  tag;
    logic [23:0] data;
  } msg_t;

  // Default depth of the source and sink tables
  localparam int MAX_MSGS = 64;

  //--------------------------------------------------------------------
  // Control states
  //--------------------------------------------------------------------

  typedef enum logic [1:0] {
    state_idle   = 2'd0,
    state_run    = 2'd1,
    state_finish = 2'd2
  } harness_state_t;

endpackage

`default_nettype wire
